// File: source/spi_periph_config.svh
`ifndef SPI_PERIPH_CONFIG_SVH
`define SPI_PERIPH_CONFIG_SVH

// ******************************
// SPI mode of the slave port
// ******************************

// Idle level of SCLK
`define SPI_CPOL 1'b0
// Zero samples MOSI on the leading edge, one samples on the trailing edge
`define SPI_CPHA 1'b0
// Set for an active high chip select
`define SPI_INV_CS 1'b0

// ******************************
// Data path sizes
// ******************************

`define SPI_WORD_BITS 16
// Reply sent whenever the host has not queued a reply word
`define SPI_DEFAULT_MISO 16'hCAFE
`define SPI_FIFO_DEPTH 4

`endif

// File: source/spi_periph_pkg.sv
`include "spi_periph_config.svh"

package spi_periph_pkg;

  // One SPI frame worth of data
  typedef logic [`SPI_WORD_BITS-1:0] spi_word_t;

  // Pulses from the pin synchronizer, mosi is a plain level
  typedef struct packed {
    logic frame_start;
    logic frame_end;
    logic sample;
    logic shift;
    logic mosi;
  } spi_event_t;

  // Completed receive word, valid pulses for one cycle
  typedef struct packed {
    logic      valid;
    spi_word_t data;
  } rx_word_t;

  typedef enum logic {
    IDLE   = 1'b0,
    ACTIVE = 1'b1
  } shifter_state_e;

  // Register map of the host port
  typedef enum logic [3:0] {
    ADDR_STATUS  = 4'h0,
    ADDR_RX_DATA = 4'h4,
    ADDR_TX_DATA = 4'h8
  } reg_addr_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // Signals driven by the AXI4-Lite master
  typedef struct packed {
    logic        awvalid;
    logic [3:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [3:0]  araddr;
    logic        rready;
  } axil_req_t;

  // Signals driven back by the register block
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    axi_resp_e   bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    axi_resp_e   rresp;
  } axil_rsp_t;

endpackage

// File: source/spi_pin_sync.sv
`include "spi_periph_config.svh"

module spi_pin_sync (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       sclk,
  input  logic                       cs,
  input  logic                       mosi,
  output spi_periph_pkg::spi_event_t spi_event
);

  // Reset values match the idle pins so leaving reset shows no edge
  localparam logic SCLK_IDLE = `SPI_CPOL;
  localparam logic CS_IDLE   = ~(`SPI_INV_CS);

  logic [1:0] sclk_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sclk_prev;
  logic       cs_act;
  logic       cs_act_prev;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       lead_edge;
  logic       trail_edge;

  // ******************************
  // Two flop synchronizers followed by the edge detect stage
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sclk_sync   <= {2{SCLK_IDLE}};
      cs_sync     <= {2{CS_IDLE}};
      mosi_sync   <= 2'b00;
      sclk_prev   <= SCLK_IDLE;
      cs_act_prev <= 1'b0;
    end else begin
      sclk_sync   <= {sclk_sync[0], sclk};
      cs_sync     <= {cs_sync[0], cs};
      mosi_sync   <= {mosi_sync[0], mosi};
      sclk_prev   <= sclk_sync[1];
      cs_act_prev <= cs_act;
    end
  end

  // Chip select as an active high level whatever the pin polarity
  assign cs_act = ~(cs_sync[1] ^ `SPI_INV_CS);

  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;

  // The leading edge leaves the idle level and the trailing edge returns to it
  assign lead_edge  = (`SPI_CPOL) ? sclk_fall : sclk_rise;
  assign trail_edge = (`SPI_CPOL) ? sclk_rise : sclk_fall;

  // ******************************
  // Event outputs
  // ******************************

  assign spi_event.frame_start = cs_act & ~cs_act_prev;
  assign spi_event.frame_end   = ~cs_act & cs_act_prev;
  // Clock edges only count inside a frame
  assign spi_event.sample      = cs_act & ((`SPI_CPHA) ? trail_edge : lead_edge);
  assign spi_event.shift       = cs_act & ((`SPI_CPHA) ? lead_edge : trail_edge);
  // MOSI comes from the same stage as SCLK so the two stay aligned
  assign spi_event.mosi        = mosi_sync[1];

  // The master keeps SCLK quiet while chip select opens or closes a frame
  assert property (@(posedge clk) disable iff (!rst_n)
    (spi_event.frame_start || spi_event.frame_end) |-> !(sclk_rise || sclk_fall))
    else $error("spi_pin_sync: SCLK edge in the cycle chip select changed");

endmodule

// File: source/spi_word_shifter.sv
`include "spi_periph_config.svh"

module spi_word_shifter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  spi_periph_pkg::spi_event_t spi_event,
  input  spi_periph_pkg::spi_word_t  reply_word,
  input  logic                       reply_pending,
  output logic                       reply_taken,
  output spi_periph_pkg::rx_word_t   rx_word,
  output logic                       miso
);

  localparam int WORD_BITS = `SPI_WORD_BITS;
  // The counter has to reach WORD_BITS to mark a full word
  localparam int CNT_W = $clog2(WORD_BITS + 1);

  spi_periph_pkg::shifter_state_e state;
  spi_periph_pkg::spi_word_t      rx_shift;
  spi_periph_pkg::spi_word_t      tx_shift;
  spi_periph_pkg::spi_word_t      reply_sel;
  logic [CNT_W-1:0]               bit_cnt;
  logic                           word_full;
  logic                           last_bit;
  logic                           take_bit;
  logic                           rx_valid;

  // Host reply if one is queued, otherwise the fixed default word
  assign reply_sel = reply_pending ? reply_word :
                     spi_periph_pkg::spi_word_t'(`SPI_DEFAULT_MISO);

  // The queued reply is consumed as soon as a frame opens
  assign reply_taken = spi_event.frame_start & reply_pending;

  assign word_full = (bit_cnt == CNT_W'(WORD_BITS));
  assign last_bit  = (bit_cnt == CNT_W'(WORD_BITS - 1));

  // Only bits inside an open frame and within one word are kept
  assign take_bit = (state == spi_periph_pkg::ACTIVE) && spi_event.sample && !word_full &&
                    !spi_event.frame_start && !spi_event.frame_end;

  // ******************************
  // Frame FSM and bit counter
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= spi_periph_pkg::IDLE;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (spi_event.frame_start) begin
        state   <= spi_periph_pkg::ACTIVE;
        bit_cnt <= '0;
      end else if (spi_event.frame_end) begin
        // A short frame just drops its partial word here
        state <= spi_periph_pkg::IDLE;
      end
      if (take_bit) begin
        bit_cnt  <= bit_cnt + 1'b1;
        rx_valid <= last_bit;
      end
    end
  end

  // Receive shift register, MSB arrives first
  always_ff @(posedge clk) begin
    if (take_bit) begin
      rx_shift <= {rx_shift[WORD_BITS-2:0], spi_event.mosi};
    end
  end

  assign rx_word.valid = rx_valid;
  assign rx_word.data  = rx_shift;

  // ******************************
  // Transmit side
  // ******************************

  // MISO and the transmit word form one register chain shifted left
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      miso     <= 1'b0;
      tx_shift <= '0;
    end else if (spi_event.frame_start) begin
      if (`SPI_CPHA == 0) begin
        // With CPHA zero the first bit must be out before the first edge
        {miso, tx_shift} <= {reply_sel, 1'b0};
      end else begin
        tx_shift <= reply_sel;
      end
    end else if (spi_event.frame_end) begin
      miso <= 1'b0;
    end else if (state == spi_periph_pkg::ACTIVE && spi_event.shift) begin
      {miso, tx_shift} <= {tx_shift, 1'b0};
    end
  end

  // A word can only complete while a frame is open
  assert property (@(posedge clk) disable iff (!rst_n)
    rx_word.valid |-> state == spi_periph_pkg::ACTIVE)
    else $error("spi_word_shifter: received word outside of a frame");

endmodule

// File: source/spi_rx_fifo.sv
`include "spi_periph_config.svh"

module spi_rx_fifo #(
  parameter int DEPTH = `SPI_FIFO_DEPTH
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  spi_periph_pkg::rx_word_t  rx_word,
  input  logic                      pop,
  input  logic                      overflow_clear,
  output spi_periph_pkg::spi_word_t head,
  output logic [3:0]                count,
  output logic                      overflow
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  spi_periph_pkg::spi_word_t mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic                      full;
  logic                      push;
  logic                      do_pop;

  // Pointers wrap at DEPTH so the depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign full   = (count == 4'(DEPTH));
  // The shifter is never stalled, a word that finds no room is lost
  assign push   = rx_word.valid && !full;
  assign do_pop = pop && (count != 4'd0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= rx_word.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= 4'd0;
      overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, do_pop})
        2'b10:   count <= count + 4'd1;
        2'b01:   count <= count - 4'd1;
        default: count <= count;
      endcase
      // A new loss wins over a clear in the same cycle
      if (rx_word.valid && full) begin
        overflow <= 1'b1;
      end else if (overflow_clear) begin
        overflow <= 1'b0;
      end
    end
  end

  assign head = mem[rd_ptr];

  assert property (@(posedge clk) disable iff (!rst_n) count <= 4'(DEPTH))
    else $error("spi_rx_fifo: count above depth");

endmodule

// File: source/spi_axil_regs.sv
module spi_axil_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  spi_periph_pkg::axil_req_t axil_req,
  output spi_periph_pkg::axil_rsp_t axil_rsp,
  input  spi_periph_pkg::spi_word_t head,
  input  logic [3:0]                count,
  input  logic                      overflow,
  output logic                      pop,
  output logic                      overflow_clear,
  output spi_periph_pkg::spi_word_t reply_word,
  output logic                      reply_pending,
  input  logic                      reply_taken
);

  spi_periph_pkg::reg_addr_e wr_addr;
  spi_periph_pkg::reg_addr_e rd_addr;
  spi_periph_pkg::axi_resp_e wr_resp;
  spi_periph_pkg::axi_resp_e rd_resp;
  spi_periph_pkg::axi_resp_e bresp;
  spi_periph_pkg::axi_resp_e rresp;
  logic                      wr_fire;
  logic                      rd_fire;
  logic                      tx_write;
  logic                      bvalid;
  logic                      rvalid;
  logic [31:0]               rd_value;
  logic [31:0]               rdata;

  assign wr_addr = spi_periph_pkg::reg_addr_e'(axil_req.awaddr);
  assign rd_addr = spi_periph_pkg::reg_addr_e'(axil_req.araddr);

  // Address and data are taken together, and never while a response waits
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;
  assign rd_fire = axil_req.arvalid && !rvalid;

  // ******************************
  // Write decode
  // ******************************

  always_comb begin
    wr_resp        = spi_periph_pkg::OKAY;
    tx_write       = 1'b0;
    overflow_clear = 1'b0;
    case (wr_addr)
      spi_periph_pkg::ADDR_STATUS:  overflow_clear = wr_fire && axil_req.wdata[8];
      spi_periph_pkg::ADDR_TX_DATA: tx_write = wr_fire;
      // RX_DATA is read only
      default:                      wr_resp = spi_periph_pkg::SLVERR;
    endcase
  end

  // ******************************
  // Read decode
  // ******************************

  always_comb begin
    rd_resp  = spi_periph_pkg::OKAY;
    rd_value = 32'd0;
    case (rd_addr)
      spi_periph_pkg::ADDR_STATUS:  rd_value = {23'd0, overflow, 4'd0, count};
      // An empty FIFO reads as zero
      spi_periph_pkg::ADDR_RX_DATA: rd_value = (count != 4'd0) ? 32'(head) : 32'd0;
      spi_periph_pkg::ADDR_TX_DATA: rd_value = 32'(reply_word);
      default:                      rd_resp = spi_periph_pkg::SLVERR;
    endcase
  end

  assign pop = rd_fire && (rd_addr == spi_periph_pkg::ADDR_RX_DATA) && (count != 4'd0);

  // Response channels hold until the master takes them
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      bresp  <= spi_periph_pkg::OKAY;
      rresp  <= spi_periph_pkg::OKAY;
    end else begin
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= wr_resp;
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
        rresp  <= rd_resp;
      end else if (axil_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_value;
    end
  end

  // ******************************
  // Reply word for the next frame
  // ******************************

  always_ff @(posedge clk) begin
    if (tx_write) begin
      reply_word <= spi_periph_pkg::spi_word_t'(axil_req.wdata);
    end
  end

  // A fresh write overrides the shifter taking the old reply
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reply_pending <= 1'b0;
    end else if (tx_write) begin
      reply_pending <= 1'b1;
    end else if (reply_taken) begin
      reply_pending <= 1'b0;
    end
  end

  assign axil_rsp.awready = wr_fire;
  assign axil_rsp.wready  = wr_fire;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = bresp;
  assign axil_rsp.arready = rd_fire;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = rresp;

  // Write response stays up with the same code until bready
  assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !axil_req.bready |=> bvalid && $stable(bresp))
    else $error("spi_axil_regs: write response dropped before bready");

endmodule

// File: source/spi_periph_top.sv
`include "spi_periph_config.svh"

module spi_periph_top (
  input  logic        clk,
  input  logic        rst_n,
  // SPI slave pins
  input  logic        sclk,
  input  logic        cs,
  input  logic        mosi,
  output logic        miso,
  // AXI4-Lite slave
  input  logic        awvalid,
  output logic        awready,
  input  logic [3:0]  awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  input  logic        arvalid,
  output logic        arready,
  input  logic [3:0]  araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp
);

  spi_periph_pkg::spi_event_t spi_event;
  spi_periph_pkg::rx_word_t   rx_word;
  spi_periph_pkg::spi_word_t  head;
  spi_periph_pkg::spi_word_t  reply_word;
  spi_periph_pkg::axil_req_t  axil_req;
  spi_periph_pkg::axil_rsp_t  axil_rsp;
  logic [3:0]                 count;
  logic                       overflow;
  logic                       pop;
  logic                       overflow_clear;
  logic                       reply_pending;
  logic                       reply_taken;

  // ******************************
  // AXI4-Lite bundling
  // ******************************

  assign axil_req.awvalid = awvalid;
  assign axil_req.awaddr  = awaddr;
  assign axil_req.wvalid  = wvalid;
  assign axil_req.wdata   = wdata;
  assign axil_req.bready  = bready;
  assign axil_req.arvalid = arvalid;
  assign axil_req.araddr  = araddr;
  assign axil_req.rready  = rready;

  assign awready = axil_rsp.awready;
  assign wready  = axil_rsp.wready;
  assign bvalid  = axil_rsp.bvalid;
  assign bresp   = axil_rsp.bresp;
  assign arready = axil_rsp.arready;
  assign rvalid  = axil_rsp.rvalid;
  assign rdata   = axil_rsp.rdata;
  assign rresp   = axil_rsp.rresp;

  // ******************************
  // Pipeline from pins to host
  // ******************************

  spi_pin_sync spi_pin_sync_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .spi_event (spi_event)
  );

  spi_word_shifter spi_word_shifter_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .spi_event     (spi_event),
    .reply_word    (reply_word),
    .reply_pending (reply_pending),
    .reply_taken   (reply_taken),
    .rx_word       (rx_word),
    .miso          (miso)
  );

  spi_rx_fifo #(
    .DEPTH (`SPI_FIFO_DEPTH)
  ) spi_rx_fifo_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx_word        (rx_word),
    .pop            (pop),
    .overflow_clear (overflow_clear),
    .head           (head),
    .count          (count),
    .overflow       (overflow)
  );

  spi_axil_regs spi_axil_regs_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .axil_req       (axil_req),
    .axil_rsp       (axil_rsp),
    .head           (head),
    .count          (count),
    .overflow       (overflow),
    .pop            (pop),
    .overflow_clear (overflow_clear),
    .reply_word     (reply_word),
    .reply_pending  (reply_pending),
    .reply_taken    (reply_taken)
  );

endmodule

// File: bench/spi_clock_gen.sv
module spi_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset covers eight rising edges and drops just after the last one
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// File: bench/spi_periph_tb.sv
`include "spi_periph_config.svh"

module spi_periph_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int         WORD_BITS   = `SPI_WORD_BITS;
  // SCLK half period in clk cycles
  localparam int         HALF_CYCLES = 6;
  localparam int         SHORT_BITS  = 7;
  localparam int         WAIT_LIMIT  = 200;
  localparam int         POLL_LIMIT  = 40;
  localparam logic       CS_ON       = `SPI_INV_CS;
  localparam logic [3:0] STATUS_ADDR = 4'h0;
  localparam logic [3:0] TX_ADDR     = 4'h8;

  logic        clk;
  logic        rst_n;
  logic        sclk;
  logic        cs;
  logic        mosi;
  logic        miso;
  logic        awvalid;
  logic        awready;
  logic [3:0]  awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [3:0]  araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  int          error_count;
  int          tests_run;
  int          tests_failed;
  logic [31:0] rng_state;

  spi_clock_gen spi_clock_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  spi_periph_top spi_periph_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .sclk    (sclk),
    .cs      (cs),
    .mosi    (mosi),
    .miso    (miso),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  // ******************************
  // Helpers
  // ******************************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] hex_field(input string text);
    logic [31:0] value;
    int          n;
    value = '0;
    n = $sscanf(text, "%h", value);
    if (n != 1) value = '0;
    return value;
  endfunction

  task automatic report_failure(input string test, input string text);
    $display("ERROR in %s: %s", test, text);
    error_count++;
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test, what, expected, actual);
      error_count++;
    end
  endtask

  // Every drive lands 1 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // ******************************
  // AXI4-Lite master
  // ******************************

  task automatic axi_write(input string test, input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int   waited;
    logic done;
    resp    = 2'b11;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waited  = 0;
    done    = 1'b0;
    // Ready is sampled mid cycle and the transfer takes place on the next rising edge
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge clk);
      done = awready && wready;
      wait_cycles(1);
      waited++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!done) begin
      report_failure(test, "write address and data were never accepted");
    end else begin
      bready = 1'b1;
      waited = 0;
      done   = 1'b0;
      while (!done && waited < WAIT_LIMIT) begin
        @(negedge clk);
        done = bvalid;
        if (done) resp = bresp;
        wait_cycles(1);
        waited++;
      end
      bready = 1'b0;
      if (!done) report_failure(test, "no write response arrived");
    end
  endtask

  task automatic axi_read(input string test, input logic [3:0] addr,
                          output logic [31:0] data, output logic [1:0] resp);
    int   waited;
    logic done;
    data    = '0;
    resp    = 2'b11;
    araddr  = addr;
    arvalid = 1'b1;
    waited  = 0;
    done    = 1'b0;
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge clk);
      done = arready;
      wait_cycles(1);
      waited++;
    end
    arvalid = 1'b0;
    if (!done) begin
      report_failure(test, "read address was never accepted");
    end else begin
      rready = 1'b1;
      waited = 0;
      done   = 1'b0;
      while (!done && waited < WAIT_LIMIT) begin
        @(negedge clk);
        done = rvalid;
        if (done) begin
          data = rdata;
          resp = rresp;
        end
        wait_cycles(1);
        waited++;
      end
      rready = 1'b0;
      if (!done) report_failure(test, "no read data arrived");
    end
  endtask

  // The word reaches the FIFO some cycles after the frame, so STATUS is polled
  task automatic poll_count(input string test, input logic [31:0] expected);
    logic [31:0] data;
    logic [1:0]  resp;
    int          polls;
    logic        reached;
    polls   = 0;
    reached = 1'b0;
    while (!reached && polls < POLL_LIMIT) begin
      axi_read(test, STATUS_ADDR, data, resp);
      reached = ({28'd0, data[3:0]} == expected);
      polls++;
    end
    if (!reached) begin
      report_failure(test, $sformatf("STATUS count never reached %0d", expected));
    end
  endtask

  // ******************************
  // SPI master, mode 0
  // ******************************

  // Sends the top bits of word MSB first and collects MISO right justified
  task automatic spi_frame(input logic [31:0] word, input int bits, output logic [31:0] seen);
    seen = '0;
    cs   = CS_ON;
    for (int i = 0; i < bits; i++) begin
      mosi = word[WORD_BITS-1-i];
      wait_cycles(HALF_CYCLES);
      // MISO is taken just as SCLK rises
      seen = {seen[30:0], miso};
      sclk = 1'b1;
      wait_cycles(HALF_CYCLES);
      sclk = 1'b0;
    end
    wait_cycles(HALF_CYCLES);
    cs   = ~CS_ON;
    mosi = 1'b0;
  endtask

  task automatic frame_gap();
    rng_state = xorshift32(rng_state);
    wait_cycles(4 + int'(rng_state[2:0]));
  endtask

  // ******************************
  // Test kinds of the testdata file
  // ******************************

  task automatic run_frame(input string test, input string arg_s, input string reply_s,
                           input string exp_a_s, input string exp_b_s);
    logic [1:0]  resp;
    logic [31:0] seen;
    if (reply_s != "none") begin
      axi_write(test, TX_ADDR, hex_field(reply_s), resp);
      check_value(test, "reply write response", 32'd0, {30'd0, resp});
    end
    spi_frame(hex_field(arg_s), WORD_BITS, seen);
    check_value(test, "MISO word", hex_field(exp_a_s), seen);
    poll_count(test, hex_field(exp_b_s));
    frame_gap();
  endtask

  task automatic run_short(input string test, input string arg_s,
                           input string exp_a_s, input string exp_b_s);
    logic [31:0] seen;
    logic [31:0] data;
    logic [1:0]  resp;
    spi_frame(hex_field(arg_s), SHORT_BITS, seen);
    check_value(test, "MISO bits", hex_field(exp_a_s), seen);
    // A cut frame raises no event, so STATUS is read once the pipeline has drained
    wait_cycles(4 * HALF_CYCLES);
    axi_read(test, STATUS_ADDR, data, resp);
    check_value(test, "STATUS count", hex_field(exp_b_s), {28'd0, data[3:0]});
    frame_gap();
  endtask

  task automatic run_read(input string test, input string arg_s,
                          input string exp_a_s, input string exp_b_s);
    logic [31:0] addr_word;
    logic [31:0] data;
    logic [1:0]  resp;
    addr_word = hex_field(arg_s);
    axi_read(test, addr_word[3:0], data, resp);
    if (exp_a_s != "-") check_value(test, "read data", hex_field(exp_a_s), data);
    check_value(test, "read response", hex_field(exp_b_s), {30'd0, resp});
  endtask

  task automatic run_write(input string test, input string arg_s, input string reply_s,
                           input string exp_b_s);
    logic [31:0] addr_word;
    logic [1:0]  resp;
    addr_word = hex_field(arg_s);
    axi_write(test, addr_word[3:0], hex_field(reply_s), resp);
    check_value(test, "write response", hex_field(exp_b_s), {30'd0, resp});
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    int    fd;
    int    n;
    int    waited;
    int    errors_before;
    string line;
    string kind;
    string name;
    string arg_s;
    string reply_s;
    string exp_a_s;
    string exp_b_s;

    sclk         = 1'b0;
    cs           = ~CS_ON;
    mosi         = 1'b0;
    awvalid      = 1'b0;
    awaddr       = 4'h0;
    wvalid       = 1'b0;
    wdata        = 32'd0;
    bready       = 1'b0;
    arvalid      = 1'b0;
    araddr       = 4'h0;
    rready       = 1'b0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    rng_state    = 32'hbf6af5f0;

    waited = 0;
    while (rst_n !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) report_failure("reset", "reset was never released");
    wait_cycles(2);

    fd = $fopen("bench/spi_periph_testdata.txt", "r");
    if (fd == 0) begin
      report_failure("setup", "cannot open bench/spi_periph_testdata.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %s %s %s %s %s", kind, name, arg_s, reply_s, exp_a_s, exp_b_s);
        // Blank lines and comment lines carry no test
        if (n > 0 && line.getc(0) != "#") begin
          if (n != 6) begin
            report_failure("testdata", $sformatf("malformed line: %s", line));
          end else begin
            errors_before = error_count;
            tests_run++;
            if (kind == "frame") begin
              run_frame(name, arg_s, reply_s, exp_a_s, exp_b_s);
            end else if (kind == "short") begin
              run_short(name, arg_s, exp_a_s, exp_b_s);
            end else if (kind == "read") begin
              run_read(name, arg_s, exp_a_s, exp_b_s);
            end else if (kind == "write") begin
              run_write(name, arg_s, reply_s, exp_b_s);
            end else begin
              report_failure(name, $sformatf("unknown test kind %s", kind));
            end
            if (error_count == errors_before) begin
              $display("PASS %s", name);
            end else begin
              tests_failed++;
              $display("FAIL %s", name);
            end
          end
        end
      end
      $fclose(fd);
    end

    if (tests_run == 0) report_failure("setup", "no tests were read from the testdata file");
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+source
source/spi_periph_pkg.sv
source/spi_pin_sync.sv
source/spi_word_shifter.sv
source/spi_rx_fifo.sv
source/spi_axil_regs.sv
source/spi_periph_top.sv
bench/spi_clock_gen.sv
bench/spi_periph_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the SPI peripheral testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log
sim=obj_dir/spi_periph_sim

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module spi_periph_tb -f src.f --Mdir obj_dir -o spi_periph_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$sim" > "$log" 2>&1; then
  cat "$log"
  echo "Simulation exited with a failing status"
  exit 1
fi

cat "$log"

if grep -q "^Finished with no errors$" "$log"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: bench/spi_periph_testdata.txt
# Columns: kind name arg reply exp_a exp_b, values in hex, - marks a field that is not used
# frame: arg MOSI word, reply TX_DATA write or none, exp_a MISO word, exp_b FIFO count after
# short: like frame but cut after 7 bits, exp_a holds the 7 MISO bits seen
# read: arg address, exp_a read data, exp_b response; write: arg address, reply write data
frame default_reply 1357 none cafe 1
read default_rd 4 - 1357 0
frame tx_reply a5a5 1234 1234 1
frame reply_cleared 5a5a none cafe 2
read reply_rd_0 4 - a5a5 0
read reply_rd_1 4 - 5a5a 0
write reply_first 8 beef - 0
frame reply_replaced 0f0f 4321 4321 1
read replaced_rd 4 - 0f0f 0
frame order_0 0001 none cafe 1
frame order_1 8002 none cafe 2
frame order_2 ffff none cafe 3
read order_count_3 0 - 3 0
read order_rd_0 4 - 0001 0
read order_count_2 0 - 2 0
read order_rd_1 4 - 8002 0
read order_count_1 0 - 1 0
read order_rd_2 4 - ffff 0
read order_count_0 0 - 0 0
frame ovf_0 1111 none cafe 1
frame ovf_1 2222 none cafe 2
frame ovf_2 3333 none cafe 3
frame ovf_3 4444 none cafe 4
frame ovf_4 5555 none cafe 4
read ovf_status 0 - 104 0
write ovf_clear 0 100 - 0
read ovf_cleared 0 - 4 0
read ovf_rd_0 4 - 1111 0
read ovf_rd_1 4 - 2222 0
read ovf_rd_2 4 - 3333 0
read ovf_rd_3 4 - 4444 0
short short_frame 7777 none 65 0
frame after_short 9abc none cafe 1
read after_short_rd 4 - 9abc 0
read unmapped_read 2 - - 2
write unmapped_write c 1 - 2
write rx_data_write 4 0 - 2
read rx_empty 4 - 0 0
